/* source/icon_defines.svh */
`ifndef ICON_DEFINES_SVH
`define ICON_DEFINES_SVH

`default_nettype none

// tile row (qv[9:5]) carrying the status icons
`define ICON_ROW 5'd1

// tile columns (qh[9:5]) of the three icon slots
`define COL_DATE 5'd2
`define COL_HOUR 5'd3
`define COL_MERID 5'd4

// port_id value that loads the alarm latch
`define ALARM_PORT 8'h00

// glyph row width and beam coordinate width
`define GLYPH_W 32
`define POS_W 10

`default_nettype wire

`endif

/* source/icon_pkg.sv */
`include "icon_defines.svh"

`default_nettype none

package icon_pkg;

  // icon codes, also the upper bits of the rom address
  typedef enum logic [2:0] {
    ICON_BLANK    = 3'd0,
    ICON_CALENDAR = 3'd1,
    ICON_CRONO    = 3'd2,
    ICON_HORA     = 3'd3,
    ICON_AM       = 3'd4,
    ICON_PM       = 3'd5
  } icon_code_e;

  // msb is the leftmost pixel
  typedef logic [`GLYPH_W-1:0] glyph_word_t;
  typedef logic [4:0] glyph_row_t;
  typedef logic [4:0] px_col_t;
  typedef logic [4:0] tile_t;

endpackage

`default_nettype wire

/* source/glyph_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface glyph_if;

  // stage 1, from the placer
  icon_pkg::icon_code_e  code;
  icon_pkg::glyph_row_t  row;
  icon_pkg::px_col_t     col_s1;

  // stage 2, from the rom
  icon_pkg::glyph_word_t word;
  icon_pkg::px_col_t     col_s2;

  modport placer (output code, output row, output col_s1);
  modport rom (input code, input row, input col_s1, output word, output col_s2);
  modport picker (input word, input col_s2);

endinterface

`default_nettype wire

/* source/icon_placer.sv */
`include "icon_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module icon_placer (
  input  logic               reloj,
  input  logic               resetM,
  input  logic [`POS_W-1:0]  qh,
  input  logic [`POS_W-1:0]  qv,
  input  logic               f_h,
  input  logic               am_pm,
  glyph_if.placer            gl
);

  icon_pkg::tile_t      tile_col;
  icon_pkg::tile_t      tile_row;
  icon_pkg::icon_code_e next_code;

  // upper five bits pick the 32x32 tile
  assign tile_col = qh[9:5];
  assign tile_row = qv[9:5];

  // only one tile row holds icons, rest stays blank
  always_comb begin
    next_code = icon_pkg::ICON_BLANK;
    if (tile_row == `ICON_ROW) begin
      case (tile_col)
        // date slot flips to stopwatch in f_h mode
        `COL_DATE:  next_code = f_h ? icon_pkg::ICON_CRONO : icon_pkg::ICON_CALENDAR;
        `COL_HOUR:  next_code = icon_pkg::ICON_HORA;
        // meridian slot
        `COL_MERID: next_code = am_pm ? icon_pkg::ICON_PM : icon_pkg::ICON_AM;
        default:    next_code = icon_pkg::ICON_BLANK;
      endcase
    end
  end

  // stage 1 register, column rides along with code and row
  always_ff @(posedge reloj) begin
    if (!resetM) begin
      gl.code   <= icon_pkg::ICON_BLANK;
      gl.row    <= '0;
      gl.col_s1 <= '0;
    end else begin
      gl.code   <= next_code;
      gl.row    <= qv[4:0];
      gl.col_s1 <= qh[4:0];
    end
  end

endmodule

`default_nettype wire

/* source/icon_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module icon_rom (
  input  logic reloj,
  input  logic resetM,
  glyph_if.rom gl
);

  logic [7:0]            rom_addr;
  icon_pkg::glyph_word_t rom_word;

  // {code, row}, 32 words per icon
  assign rom_addr = {gl.code, gl.row};

  always_comb begin
    case (rom_addr)
      // calendar, code 1
      8'h20: rom_word = 32'h0c000c00;
      8'h21: rom_word = 32'h0c000c00;
      8'h22: rom_word = 32'h0c000c00;
      8'h23: rom_word = 32'h0c000c00;
      8'h24: rom_word = 32'h6dffed80;
      8'h25: rom_word = 32'hedffedc0;
      8'h26: rom_word = 32'hf3fff3c0;
      8'h27: rom_word = 32'hffffffc0;
      8'h28: rom_word = 32'hffffffc0;
      8'h29: rom_word = 32'hffffffc0;
      8'h2a: rom_word = 32'hc00000c0;
      8'h2b: rom_word = 32'hc00000c0;
      8'h2c: rom_word = 32'hcf3cf0c0;
      8'h2d: rom_word = 32'hcf3cf0c0;
      8'h2e: rom_word = 32'hcf3cf000;
      8'h2f: rom_word = 32'hcf3cf000;
      // small clock overlaps the lower right
      8'h30: rom_word = 32'hc00007e0;
      8'h31: rom_word = 32'hc0001ff8;
      8'h32: rom_word = 32'hcf3c3c3c;
      8'h33: rom_word = 32'hcf3c700e;
      8'h34: rom_word = 32'hcf3c6306;
      8'h35: rom_word = 32'hcf3ce307;
      8'h36: rom_word = 32'hc000c303;
      8'h37: rom_word = 32'hc000c303;
      8'h38: rom_word = 32'hfffcc3f3;
      8'h39: rom_word = 32'h7ffcc3f3;
      8'h3a: rom_word = 32'h0000e007;
      8'h3b: rom_word = 32'h00006006;
      8'h3c: rom_word = 32'h0000700e;
      8'h3d: rom_word = 32'h00003c3c;
      8'h3e: rom_word = 32'h00001ff8;
      8'h3f: rom_word = 32'h000007e0;
      // stopwatch, code 2
      8'h40: rom_word = 32'h000ff000;
      8'h41: rom_word = 32'h000ff000;
      8'h42: rom_word = 32'h0003c000;
      8'h43: rom_word = 32'h0003c000;
      8'h44: rom_word = 32'h0387e000;
      8'h45: rom_word = 32'h073ffc00;
      8'h46: rom_word = 32'h067ffe00;
      8'h47: rom_word = 32'h05f00f80;
      8'h48: rom_word = 32'h03c3c3c0;
      8'h49: rom_word = 32'h079ff9e0;
      8'h4a: rom_word = 32'h0f3ffcf0;
      8'h4b: rom_word = 32'h0e7ffe70;
      8'h4c: rom_word = 32'h1cffff38;
      8'h4d: rom_word = 32'h1dffffb8;
      8'h4e: rom_word = 32'h19ffff98;
      8'h4f: rom_word = 32'h39ffff9c;
      // digits band across the dial
      8'h50: rom_word = 32'h3b10c8dc;
      8'h51: rom_word = 32'h3b2ab4dc;
      8'h52: rom_word = 32'h3b2834dc;
      8'h53: rom_word = 32'h3b3accdc;
      8'h54: rom_word = 32'h3b0000dc;
      8'h55: rom_word = 32'h19ffff98;
      8'h56: rom_word = 32'h19ffff98;
      8'h57: rom_word = 32'h1cffff38;
      8'h58: rom_word = 32'h0e7ffe70;
      8'h59: rom_word = 32'h0e3ffc70;
      8'h5a: rom_word = 32'h071ff8e0;
      8'h5b: rom_word = 32'h0387e1c0;
      8'h5c: rom_word = 32'h01e00780;
      8'h5d: rom_word = 32'h00fe7f00;
      8'h5e: rom_word = 32'h003ffc00;
      8'h5f: rom_word = 32'h000ff000;
      // clock face, code 3, drawn inverted
      8'h60: rom_word = 32'hffffffff;
      8'h61: rom_word = 32'hffffffff;
      8'h62: rom_word = 32'hffffffff;
      8'h63: rom_word = 32'hff8003ff;
      8'h64: rom_word = 32'hff8003ff;
      8'h65: rom_word = 32'hff8001ff;
      8'h66: rom_word = 32'hffbff9ff;
      8'h67: rom_word = 32'hffbff9ff;
      8'h68: rom_word = 32'hffbff9ff;
      8'h69: rom_word = 32'hff9ffbff;
      8'h6a: rom_word = 32'hffdff3ff;
      8'h6b: rom_word = 32'hffcff7ff;
      8'h6c: rom_word = 32'hffe7e7ff;
      8'h6d: rom_word = 32'hfff3cfff;
      8'h6e: rom_word = 32'hfff81fff;
      8'h6f: rom_word = 32'hfffc3fff;
      8'h70: rom_word = 32'hfffd3fff;
      8'h71: rom_word = 32'hfff99fff;
      8'h72: rom_word = 32'hfff3cfff;
      8'h73: rom_word = 32'hffe46fff;
      8'h74: rom_word = 32'hffc007ff;
      8'h75: rom_word = 32'hffc003ff;
      8'h76: rom_word = 32'hff8003ff;
      8'h77: rom_word = 32'hff8001ff;
      8'h78: rom_word = 32'hff8001ff;
      8'h79: rom_word = 32'hff8001ff;
      8'h7a: rom_word = 32'hff8001ff;
      8'h7b: rom_word = 32'hff8003ff;
      8'h7c: rom_word = 32'hff8003ff;
      8'h7d: rom_word = 32'hffffffff;
      8'h7e: rom_word = 32'hffffffff;
      8'h7f: rom_word = 32'hffffffff;
      // am badge, code 4
      8'h80: rom_word = 32'hffffffff;
      8'h81: rom_word = 32'hffffffff;
      8'h82: rom_word = 32'hffffffff;
      8'h83: rom_word = 32'he0000007;
      8'h84: rom_word = 32'he0000007;
      8'h85: rom_word = 32'he0018007;
      8'h86: rom_word = 32'he0018007;
      8'h87: rom_word = 32'he0018007;
      8'h88: rom_word = 32'he0018007;
      8'h89: rom_word = 32'he0018007;
      8'h8a: rom_word = 32'he0018007;
      8'h8b: rom_word = 32'he0018007;
      8'h8c: rom_word = 32'he0018007;
      8'h8d: rom_word = 32'he0018007;
      8'h8e: rom_word = 32'he003c007;
      8'h8f: rom_word = 32'he0ffc007;
      8'h90: rom_word = 32'he07fc007;
      8'h91: rom_word = 32'he0018007;
      8'h92: rom_word = 32'he0000007;
      8'h93: rom_word = 32'he0000007;
      8'h94: rom_word = 32'he0000007;
      8'h95: rom_word = 32'he0000007;
      // "am" lettering
      8'h96: rom_word = 32'he079fe07;
      8'h97: rom_word = 32'he0fdfe07;
      8'h98: rom_word = 32'he07db607;
      8'h99: rom_word = 32'he0fdb607;
      8'h9a: rom_word = 32'he0ddb607;
      8'h9b: rom_word = 32'he0fd3207;
      8'h9c: rom_word = 32'he0000007;
      8'h9d: rom_word = 32'hffffffff;
      8'h9e: rom_word = 32'hffffffff;
      8'h9f: rom_word = 32'hffffffff;
      // pm badge, code 5
      8'ha0: rom_word = 32'hffffffff;
      8'ha1: rom_word = 32'hffffffff;
      8'ha2: rom_word = 32'hffffffff;
      8'ha3: rom_word = 32'hffffffff;
      8'ha4: rom_word = 32'hffffffff;
      8'ha5: rom_word = 32'hfffe7fff;
      8'ha6: rom_word = 32'hfffe7fff;
      8'ha7: rom_word = 32'hfffe7fff;
      8'ha8: rom_word = 32'hfffe7fff;
      8'ha9: rom_word = 32'hfffe7fff;
      8'haa: rom_word = 32'hfffe7fff;
      8'hab: rom_word = 32'hfffe7fff;
      8'hac: rom_word = 32'hfffe7fff;
      8'had: rom_word = 32'hfffe7fff;
      8'hae: rom_word = 32'hfffc3fff;
      8'haf: rom_word = 32'hfe003fff;
      8'hb0: rom_word = 32'hff003fff;
      8'hb1: rom_word = 32'hfffe7fff;
      8'hb2: rom_word = 32'hffffffff;
      8'hb3: rom_word = 32'hffffffff;
      8'hb4: rom_word = 32'hffffffff;
      8'hb5: rom_word = 32'hffffffff;
      8'hb6: rom_word = 32'hff0201ff;
      8'hb7: rom_word = 32'hff0200ff;
      8'hb8: rom_word = 32'hff3048ff;
      8'hb9: rom_word = 32'hff3248ff;
      8'hba: rom_word = 32'hff0248ff;
      8'hbb: rom_word = 32'hff064dff;
      8'hbc: rom_word = 32'hff3fffff;
      8'hbd: rom_word = 32'hff3fffff;
      8'hbe: rom_word = 32'hffffffff;
      8'hbf: rom_word = 32'hffffffff;
      // blank code and unused codes
      default: rom_word = '0;
    endcase
  end

  // stage 2, column delayed so it stays with its word
  always_ff @(posedge reloj) begin
    if (!resetM) begin
      gl.word   <= '0;
      gl.col_s2 <= '0;
    end else begin
      gl.word   <= rom_word;
      gl.col_s2 <= gl.col_s1;
    end
  end

endmodule

`default_nettype wire

/* source/pixel_picker.sv */
`include "icon_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module pixel_picker (
  input  logic       reloj,
  input  logic       resetM,
  input  logic [7:0] port_id,
  input  logic       bit_alarma,
  glyph_if.picker    gl,
  output logic       pixel
);

  logic              alarm_q;
  logic              margin;
  icon_pkg::px_col_t bit_idx;

  // alarm latch, loads only on its own port
  always_ff @(posedge reloj) begin
    if (!resetM) begin
      alarm_q <= 1'b0;
    end else if (port_id == `ALARM_PORT) begin
      alarm_q <= bit_alarma;
    end
  end

  // leftmost pixel sits in the msb
  assign bit_idx = 5'(`GLYPH_W - 1) - gl.col_s2;

  // first and last column of a tile stay dark
  assign margin = (gl.col_s2 == '0) || (gl.col_s2 == 5'(`GLYPH_W - 1));

  // alarm blanks the whole icon area
  assign pixel = !alarm_q && !margin && gl.word[bit_idx];

endmodule

`default_nettype wire

/* source/icon_display.sv */
`include "icon_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module icon_display (
  input  logic              reloj,
  input  logic              resetM,
  input  logic              am_pm,
  input  logic              f_h,
  input  logic [7:0]        port_id,
  input  logic              bit_alarma,
  input  logic [`POS_W-1:0] qh,
  input  logic [`POS_W-1:0] qv,
  output logic              pixel
);

  // pipeline bus between the three stages
  glyph_if gl ();

  // stage 1, beam position to icon code and row
  icon_placer u_placer (
    .reloj  (reloj),
    .resetM (resetM),
    .qh     (qh),
    .qv     (qv),
    .f_h    (f_h),
    .am_pm  (am_pm),
    .gl     (gl.placer)
  );

  // stage 2, glyph row lookup
  icon_rom u_rom (
    .reloj  (reloj),
    .resetM (resetM),
    .gl     (gl.rom)
  );

  // pixel select, margins and alarm blanking
  pixel_picker u_picker (
    .reloj      (reloj),
    .resetM     (resetM),
    .port_id    (port_id),
    .bit_alarma (bit_alarma),
    .gl         (gl.picker),
    .pixel      (pixel)
  );

endmodule

`default_nettype wire

/* dv/icon_display_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module icon_display_chk (
  input logic              reloj,
  input logic              resetM,
  input logic              pixel,
  input icon_pkg::px_col_t col_s2,
  input logic              alarm_q
);

  // first and last tile column stay dark
  a_margin: assert property (@(posedge reloj) disable iff (!resetM)
    (col_s2 == 5'd0 || col_s2 == 5'd31) |-> !pixel)
    else $error("pixel lit in a tile margin column");

  // alarm blanks everything
  a_alarm: assert property (@(posedge reloj) disable iff (!resetM)
    alarm_q |-> !pixel)
    else $error("pixel lit while the alarm latch is set");

  // pipeline cleared by reset
  a_reset_clear: assert property (@(posedge reloj) !resetM |=> !pixel)
    else $error("pixel lit in the cycle after reset");

endmodule

bind icon_display icon_display_chk chk0 (
  .reloj   (reloj),
  .resetM  (resetM),
  .pixel   (pixel),
  .col_s2  (gl.col_s2),
  .alarm_q (u_picker.alarm_q)
);

`default_nettype wire

/* dv/tb_icon_display.sv */
`include "icon_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module tb_icon_display;

  // 32 swept columns plus 2 blank flush cycles per entry
  localparam int NUM_TESTS = 17;
  localparam int CYCLES_PER_TEST = 34;
  localparam int CYCLE_LIMIT = NUM_TESTS * CYCLES_PER_TEST + 40;

  typedef struct packed {
    logic [4:0]  tile_row;
    logic [4:0]  tile_col;
    logic [4:0]  row;
    logic        f_h;
    logic        am_pm;
    logic [7:0]  port;
    logic        alarm;
    logic [31:0] word;
  } test_t;

  logic              reloj;
  logic              resetM;
  logic              am_pm;
  logic              f_h;
  logic [7:0]        port_id;
  logic              bit_alarma;
  logic [`POS_W-1:0] qh;
  logic [`POS_W-1:0] qv;
  logic              pixel;

  test_t             tbl [NUM_TESTS];
  logic [31:0]       seed;
  logic              alarm_model;
  // expected pixel of the last two positions, [1] is the older one
  logic              exp_pipe [2];
  logic [`POS_W-1:0] qh_pipe [2];
  logic [`POS_W-1:0] qv_pipe [2];
  int                cycles = 0;
  int                checks;
  int                errors;
  int                failed_tests;

  icon_display dut0 (
    .reloj      (reloj),
    .resetM     (resetM),
    .am_pm      (am_pm),
    .f_h        (f_h),
    .port_id    (port_id),
    .bit_alarma (bit_alarma),
    .qh         (qh),
    .qv         (qv),
    .pixel      (pixel)
  );

  // 8 ns period
  always #4 reloj = ~reloj;

  // watchdog on total run length
  always @(posedge reloj) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // margins dark, column c shows bit 31-c
  function automatic logic glyph_pixel(input logic [31:0] word, input logic [4:0] col);
    if (col == 5'd0 || col == 5'd31) begin
      return 1'b0;
    end
    return word[5'd31 - col];
  endfunction

  // one clock: check the position from two cycles back, then drive the next
  task automatic apply_cycle(input logic rst, input logic [`POS_W-1:0] h,
                             input logic [`POS_W-1:0] v, input logic fh, input logic ap,
                             input logic [7:0] port, input logic alarm,
                             input logic [31:0] word);
    logic want;
    @(negedge reloj);
    checks = checks + 1;
    if (pixel !== exp_pipe[1]) begin
      errors = errors + 1;
      $display("[FAIL] t=%0t pixel %b, expected %b for qh=%0d qv=%0d",
               $time, pixel, exp_pipe[1], qh_pipe[1], qv_pipe[1]);
    end
    // latch follows the next edge
    if (!rst) begin
      alarm_model = 1'b0;
    end else if (port == `ALARM_PORT) begin
      alarm_model = alarm;
    end
    want = rst && !alarm_model && glyph_pixel(word, h[4:0]);
    exp_pipe[1] = exp_pipe[0];
    qh_pipe[1]  = qh_pipe[0];
    qv_pipe[1]  = qv_pipe[0];
    exp_pipe[0] = want;
    qh_pipe[0]  = h;
    qv_pipe[0]  = v;
    resetM     = rst;
    qh         = h;
    qv         = v;
    f_h        = fh;
    am_pm      = ap;
    port_id    = port;
    bit_alarma = alarm;
  endtask

  // random spot off the icon row, always blank
  task automatic apply_filler(input logic rst, input logic [7:0] port, input logic alarm);
    logic [4:0] trow;
    seed = lcg_step(seed);
    trow = seed[20:16];
    if (trow == `ICON_ROW) begin
      trow = 5'd9;
    end
    apply_cycle(rst, seed[9:0], {trow, seed[27:23]}, seed[30], seed[31], port, alarm,
                32'h0);
  endtask

  // tile row, tile col, glyph row, f_h, am_pm, port_id, bit_alarma, row word
  task automatic fill_table();
    tbl[0]  = '{`ICON_ROW, `COL_HOUR,  5'd0, 1'b0, 1'b0, 8'h00, 1'b0, 32'hffffffff};
    tbl[1]  = '{`ICON_ROW, `COL_HOUR,  5'd2, 1'b1, 1'b1, 8'h00, 1'b0, 32'hffffffff};
    tbl[2]  = '{`ICON_ROW, `COL_MERID, 5'd3, 1'b0, 1'b0, 8'h00, 1'b0, 32'he0000007};
    tbl[3]  = '{`ICON_ROW, `COL_MERID, 5'd1, 1'b0, 1'b1, 8'h00, 1'b0, 32'hffffffff};
    tbl[4]  = '{`ICON_ROW, `COL_MERID, 5'd4, 1'b1, 1'b1, 8'h00, 1'b0, 32'hffffffff};
    tbl[5]  = '{`ICON_ROW, `COL_DATE,  5'd3, 1'b0, 1'b0, 8'h00, 1'b0, 32'h0c000c00};
    tbl[6]  = '{`ICON_ROW, `COL_DATE,  5'd1, 1'b1, 1'b0, 8'h00, 1'b0, 32'h000ff000};
    tbl[7]  = '{`ICON_ROW, `COL_DATE,  5'd0, 1'b1, 1'b1, 8'h00, 1'b0, 32'h000ff000};
    // blank tiles, in and off the icon row
    tbl[8]  = '{`ICON_ROW, 5'd7,       5'd0, 1'b0, 1'b0, 8'h00, 1'b0, 32'h00000000};
    tbl[9]  = '{`ICON_ROW, 5'd1,       5'd5, 1'b1, 1'b0, 8'h00, 1'b0, 32'h00000000};
    tbl[10] = '{5'd2,      `COL_HOUR,  5'd0, 1'b0, 1'b0, 8'h00, 1'b0, 32'h00000000};
    // alarm set, then writes to other ports, then cleared
    tbl[11] = '{`ICON_ROW, `COL_HOUR,  5'd1, 1'b0, 1'b0, 8'h00, 1'b1, 32'hffffffff};
    tbl[12] = '{`ICON_ROW, `COL_MERID, 5'd3, 1'b0, 1'b0, 8'h5a, 1'b0, 32'he0000007};
    tbl[13] = '{`ICON_ROW, `COL_MERID, 5'd0, 1'b0, 1'b0, 8'h11, 1'b1, 32'hffffffff};
    tbl[14] = '{`ICON_ROW, `COL_HOUR,  5'd2, 1'b0, 1'b0, 8'h00, 1'b0, 32'hffffffff};
    tbl[15] = '{`ICON_ROW, `COL_MERID, 5'd3, 1'b0, 1'b0, 8'h33, 1'b1, 32'he0000007};
    tbl[16] = '{`ICON_ROW, `COL_DATE,  5'd2, 1'b0, 1'b0, 8'h00, 1'b0, 32'h0c000c00};
  endtask

  initial begin
    int         err_before;
    logic [4:0] start;
    logic [4:0] col;
    reloj        = 1'b0;
    resetM       = 1'b0;
    am_pm        = 1'b0;
    f_h          = 1'b0;
    port_id      = 8'h00;
    bit_alarma   = 1'b0;
    qh           = {`COL_HOUR, 5'd5};
    qv           = {`ICON_ROW, 5'd0};
    seed         = 32'hff36_d413;
    alarm_model  = 1'b0;
    exp_pipe[0]  = 1'b0;
    exp_pipe[1]  = 1'b0;
    qh_pipe[0]   = '0;
    qh_pipe[1]   = '0;
    qv_pipe[0]   = '0;
    qv_pipe[1]   = '0;
    checks       = 0;
    errors       = 0;
    failed_tests = 0;
    fill_table();

    // reset for 3 edges with lit clock-face positions on the inputs
    for (int i = 0; i < 3; i++) begin
      seed = lcg_step(seed);
      apply_cycle(i == 2, {`COL_HOUR, seed[4:0]}, {`ICON_ROW, 5'd0}, 1'b0, 1'b0, 8'h00,
                  1'b0, 32'hffffffff);
    end
    apply_filler(1'b1, 8'h00, 1'b0);
    apply_filler(1'b1, 8'h00, 1'b0);
    if (errors == 0) begin
      $display("test reset: passed");
    end else begin
      failed_tests = failed_tests + 1;
      $display("test reset: failed with %0d errors", errors);
    end

    for (int t = 0; t < NUM_TESTS; t++) begin
      err_before = errors;
      // random starting column, sweep wraps to cover all 32
      seed = lcg_step(seed);
      start = seed[4:0];
      for (int i = 0; i < 32; i++) begin
        col = start + 5'(i);
        apply_cycle(1'b1, {tbl[t].tile_col, col}, {tbl[t].tile_row, tbl[t].row},
                    tbl[t].f_h, tbl[t].am_pm, tbl[t].port, tbl[t].alarm, tbl[t].word);
      end
      // flush keeps port and alarm so the latch holds
      apply_filler(1'b1, tbl[t].port, tbl[t].alarm);
      apply_filler(1'b1, tbl[t].port, tbl[t].alarm);
      if (errors == err_before) begin
        $display("test %0d: tile (%0d,%0d) row %0d passed", t, tbl[t].tile_row,
                 tbl[t].tile_col, tbl[t].row);
      end else begin
        failed_tests = failed_tests + 1;
        $display("test %0d: tile (%0d,%0d) row %0d failed with %0d errors", t,
                 tbl[t].tile_row, tbl[t].tile_col, tbl[t].row, errors - err_before);
      end
    end

    $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d", NUM_TESTS + 1,
             failed_tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+source
source/icon_pkg.sv
source/glyph_if.sv
source/icon_placer.sv
source/icon_rom.sv
source/pixel_picker.sv
source/icon_display.sv
dv/icon_display_chk.sv
dv/tb_icon_display.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_icon_display
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
